/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/mem_pkg.sv
      - src/fetch_pkg.sv
      - src/dual_port_ram.sv
      - src/fetch_unit.sv
      - src/instr_queue.sv
      - src/branch_predecoder.sv
      - src/fetch_subsystem_top.sv

  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/tb_fetch_subsystem.sv

/* src/branch_predecoder.sv */
// pops instructions on request, flags always-taken branches and issues fetch redirects.
`timescale 1ns/10ps

module branch_predecoder
(
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  logic                  i_take,
        input  fetch_pkg::fetched_t   i_head,
        input  logic                  i_empty,
        output logic                  o_pop,
        output logic                  o_redirect,
        output logic [31:0]           o_redirect_pc,
        output logic                  o_insn_valid,
        output fetch_pkg::predecode_t o_insn
);

        logic           is_branch;
        logic [31:0]    offset;
        fetch_pkg::pc_t target;

        assign o_pop = i_take && !i_empty;
        assign is_branch = (i_head.insn[31:24] == fetch_pkg::BRANCH_OPCODE);

        // signed word offset turned into bytes.
        assign offset = {{6{i_head.insn[23]}}, i_head.insn[23:0], 2'b00};
        assign target = i_head.pc + 32'd8 + offset;     // pc reads two words ahead.

        assign o_redirect = o_pop && is_branch;
        assign o_redirect_pc = target;

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                        o_insn_valid <= 1'b0;
                else
                        o_insn_valid <= o_pop;
        end

        always_ff @(posedge i_clk)
        begin
                if (o_pop)
                begin
                        o_insn.entry     <= i_head;
                        o_insn.is_branch <= is_branch;
                        o_insn.target    <= target;
                end
        end

        // the flush at the redirect edge leaves nothing stale behind.
        a_flush_after_redirect: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_redirect |=> i_empty);

endmodule

/* src/dual_port_ram.sv */
// byte-masked dual-port word memory with a collision stall on the read-only port.
`timescale 1ns/10ps
`include "mem_macros.svh"

module dual_port_ram
#(
        parameter int SIZE_IN_BYTES = `MEM_SIZE_BYTES
)
(
        input  logic             i_clk,
        input  logic             i_rst_n,
        input  mem_pkg::rw_req_t i_rw_req,
        input  mem_pkg::ro_req_t i_ro_req,
        output mem_pkg::word_t   o_rw_rdata,
        output mem_pkg::word_t   o_ro_rdata,
        output logic             o_ro_stall
);

        localparam int WORDS = SIZE_IN_BYTES / mem_pkg::BYTES_PER_WORD;
        localparam int IDX_W = $clog2(WORDS);
        localparam int OFS_W = $clog2(mem_pkg::BYTES_PER_WORD);

        mem_pkg::word_t ram [WORDS] = '{default: '0};     // starts cleared.

        logic [IDX_W-1:0] rw_idx;
        logic [IDX_W-1:0] ro_idx;
        logic             same_word;

        assign rw_idx = i_rw_req.addr[OFS_W +: IDX_W];     // byte offset dropped.
        assign ro_idx = i_ro_req.addr[OFS_W +: IDX_W];
        assign same_word = (i_rw_req.addr[31:OFS_W] == i_ro_req.addr[31:OFS_W]);

        // a read of the word being written waits one cycle.
        assign o_ro_stall = i_ro_req.ren && i_rw_req.wen && same_word;

        always_ff @(posedge i_clk)
        begin
                if (i_rw_req.ren)
                        o_rw_rdata <= ram[rw_idx];     // old contents on a same-cycle write.

                if (i_rw_req.wen)
                begin
                        for (int b = 0; b < mem_pkg::BYTES_PER_WORD; b++)
                        begin
                                if (i_rw_req.ben[b])
                                        ram[rw_idx][8*b +: 8] <= i_rw_req.wdata[8*b +: 8];
                        end
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_ro_req.ren && !o_ro_stall)
                        o_ro_rdata <= ram[ro_idx];
        end

        // a stalled request must leave the returned word as it was.
        a_ro_stall_holds_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_ro_stall |=> $stable(o_ro_rdata));

        a_rw_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (i_rw_req.wen || i_rw_req.ren) |-> (i_rw_req.addr < SIZE_IN_BYTES));

        a_ro_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                i_ro_req.ren |-> (i_ro_req.addr < SIZE_IN_BYTES));

endmodule

/* src/fetch_pkg.sv */
// instruction stream types, the fetched-instruction struct and the predecode result struct.
`include "mem_macros.svh"

package fetch_pkg;

        typedef logic [31:0]        pc_t;
        typedef logic [`DATA_W-1:0] insn_word_t;

        // top byte of an always-taken branch.
        localparam logic [7:0] BRANCH_OPCODE = 8'hEA;

        // one instruction word with the address it came from.
        typedef struct packed {
                pc_t        pc;
                insn_word_t insn;
        } fetched_t;

        // what the predecoder hands to the consumer.
        typedef struct packed {
                fetched_t entry;
                logic     is_branch;
                pc_t      target;       // only meaningful for branches.
        } predecode_t;

endpackage

/* src/fetch_subsystem_top.sv */
// top level tying the memory, fetch unit, instruction queue and predecoder together.
`timescale 1ns/10ps
`include "mem_macros.svh"

module fetch_subsystem_top
(
        input  logic                  i_clk,
        input  logic                  i_rst_n,
        input  mem_pkg::rw_req_t      i_rw_req,
        input  logic                  i_fetch_en,
        input  logic [31:0]           i_start_pc,
        input  logic                  i_take,
        output mem_pkg::word_t        o_rw_rdata,
        output logic                  o_insn_valid,
        output fetch_pkg::predecode_t o_insn
);

        mem_pkg::ro_req_t                  ro_req;
        mem_pkg::word_t                    ro_rdata;
        logic                              ro_stall;
        logic                              push;
        fetch_pkg::fetched_t               push_data;
        logic [$clog2(`QUEUE_DEPTH+1)-1:0] count;
        logic                              pop;
        fetch_pkg::fetched_t               head;
        logic                              empty;
        logic                              redirect;
        logic [31:0]                       redirect_pc;

        dual_port_ram #(.SIZE_IN_BYTES(`MEM_SIZE_BYTES)) u_ram (
                .i_clk      (i_clk),
                .i_rst_n    (i_rst_n),
                .i_rw_req   (i_rw_req),
                .i_ro_req   (ro_req),
                .o_rw_rdata (o_rw_rdata),
                .o_ro_rdata (ro_rdata),
                .o_ro_stall (ro_stall)
        );

        fetch_unit u_fetch (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_fetch_en    (i_fetch_en),
                .i_start_pc    (i_start_pc),
                .i_ro_stall    (ro_stall),
                .i_ro_rdata    (ro_rdata),
                .i_count       (count),
                .i_redirect    (redirect),
                .i_redirect_pc (redirect_pc),
                .o_ro_req      (ro_req),
                .o_push        (push),
                .o_push_data   (push_data)
        );

        instr_queue #(.DEPTH(`QUEUE_DEPTH)) u_queue (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_push      (push),
                .i_push_data (push_data),
                .i_pop       (pop),
                .i_flush     (redirect),        // redirect empties the queue.
                .o_head      (head),
                .o_empty     (empty),
                .o_count     (count)
        );

        branch_predecoder u_predec (
                .i_clk         (i_clk),
                .i_rst_n       (i_rst_n),
                .i_take        (i_take),
                .i_head        (head),
                .i_empty       (empty),
                .o_pop         (pop),
                .o_redirect    (redirect),
                .o_redirect_pc (redirect_pc),
                .o_insn_valid  (o_insn_valid),
                .o_insn        (o_insn)
        );

endmodule

/* src/fetch_unit.sv */
// program-counter sequencer that issues read-only reads and pushes fetched words.
`timescale 1ns/10ps
`include "mem_macros.svh"

module fetch_unit
(
        input  logic                              i_clk,
        input  logic                              i_rst_n,
        input  logic                              i_fetch_en,
        input  logic [31:0]                       i_start_pc,
        input  logic                              i_ro_stall,
        input  mem_pkg::word_t                    i_ro_rdata,
        input  logic [$clog2(`QUEUE_DEPTH+1)-1:0] i_count,
        input  logic                              i_redirect,
        input  logic [31:0]                       i_redirect_pc,
        output mem_pkg::ro_req_t                  o_ro_req,
        output logic                              o_push,
        output fetch_pkg::fetched_t               o_push_data
);

        logic             fetch_en_q;
        logic             running;
        logic             has_space;
        logic             accept;
        fetch_pkg::pc_t   pc;
        logic             inflight_q;
        fetch_pkg::pc_t   inflight_pc;

        assign running = i_fetch_en && fetch_en_q;      // first enabled cycle loads the pc.

        // the word in flight still needs a slot.
        assign has_space = (32'(i_count) + 32'(inflight_q)) < `QUEUE_DEPTH;

        assign o_ro_req.ren = running && has_space && !i_redirect;
        assign o_ro_req.addr = pc;
        assign accept = o_ro_req.ren && !i_ro_stall;

        // a redirect in the same cycle makes the returned word stale.
        assign o_push = inflight_q && !i_redirect;
        assign o_push_data.pc = inflight_pc;
        assign o_push_data.insn = i_ro_rdata;

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        fetch_en_q <= 1'b0;
                        pc         <= '0;
                        inflight_q <= 1'b0;
                end
                else
                begin
                        fetch_en_q <= i_fetch_en;

                        if (i_fetch_en && !fetch_en_q)
                                pc <= i_start_pc;       // rising edge of enable.
                        else if (i_redirect)
                                pc <= i_redirect_pc;
                        else if (accept)
                                pc <= pc + 32'd4;

                        inflight_q <= accept;           // cleared on redirect.
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (accept)
                        inflight_pc <= pc;
        end

        // throttling must keep the queue from overflowing.
        a_no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_push |-> (32'(i_count) != `QUEUE_DEPTH));

endmodule

/* src/instr_queue.sv */
// synchronous FIFO of fetched instructions with flush and occupancy count.
`timescale 1ns/10ps
`include "mem_macros.svh"

module instr_queue
#(
        parameter int DEPTH = `QUEUE_DEPTH
)
(
        input  logic                       i_clk,
        input  logic                       i_rst_n,
        input  logic                       i_push,
        input  fetch_pkg::fetched_t        i_push_data,
        input  logic                       i_pop,
        input  logic                       i_flush,
        output fetch_pkg::fetched_t        o_head,
        output logic                       o_empty,
        output logic [$clog2(DEPTH+1)-1:0] o_count
);

        localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam int CNT_W = $clog2(DEPTH + 1);
        localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
        localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

        fetch_pkg::fetched_t mem [DEPTH];

        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [CNT_W-1:0] count;
        logic             full;
        logic             do_push;
        logic             do_pop;

        // wraps for depths that are not a power of two.
        function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
                return (p == LAST_PTR) ? '0 : p + 1'b1;
        endfunction

        assign full = (count == FULL_CNT);
        assign o_empty = (count == '0);
        assign o_count = count;
        assign o_head = mem[rd_ptr];

        assign do_push = i_push && !i_flush;           // flush wins.
        assign do_pop = i_pop && !i_flush;

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end
                else if (i_flush)
                begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (do_push)
                                wr_ptr <= next_ptr(wr_ptr);
                        if (do_pop)
                                rd_ptr <= next_ptr(rd_ptr);

                        case ({do_push, do_pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;        // both or neither.
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (do_push)
                        mem[wr_ptr] <= i_push_data;
        end

        a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !(i_push && full));

        a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                !(i_pop && o_empty));

endmodule

/* src/mem_macros.svh */
// memory size, data word width and instruction queue depth macros.
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// memory size in bytes.
`define MEM_SIZE_BYTES 4096

// width of one memory word and one instruction.
`define DATA_W 32

// entries in the instruction queue.
`define QUEUE_DEPTH 4

`endif

/* src/mem_pkg.sv */
// memory port types, the read-write request struct and the read-only request struct.
`include "mem_macros.svh"

package mem_pkg;

        localparam int BYTES_PER_WORD = `DATA_W / 8;

        typedef logic [31:0]               addr_t;      // byte address.
        typedef logic [`DATA_W-1:0]        word_t;
        typedef logic [BYTES_PER_WORD-1:0] ben_t;       // one bit per byte lane.

        // read-write port request, write and read may share a cycle.
        typedef struct packed {
                logic  wen;
                logic  ren;
                ben_t  ben;
                addr_t addr;
                word_t wdata;
        } rw_req_t;

        // read-only port request.
        typedef struct packed {
                logic  ren;
                addr_t addr;
        } ro_req_t;

endpackage

/* tb.f */
+incdir+src
+incdir+verification
src/mem_pkg.sv
src/fetch_pkg.sv
src/dual_port_ram.sv
src/fetch_unit.sv
src/instr_queue.sv
src/branch_predecoder.sv
src/fetch_subsystem_top.sv
verification/tb_fetch_subsystem.sv

/* verification/tb_fetch_checks.svh */
// error counters, compare tasks for memory words and predecoded instructions, failure notes.

int word_errors  = 0;
int insn_errors  = 0;
int other_errors = 0;

task automatic check_word(input string name, input mem_pkg::word_t exp,
                          input mem_pkg::word_t act);
        if (act !== exp)
        begin
                $display("FAILED %s: expected %h, actual %h", name, exp, act);
                word_errors++;
        end
endtask

// fields shown as pc, word, branch flag, target.
task automatic check_insn(input string name, input fetch_pkg::predecode_t exp,
                          input fetch_pkg::predecode_t act);
        if (act !== exp)
        begin
                $display("FAILED %s: expected %h %h %b %h, actual %h %h %b %h",
                         name, exp.entry.pc, exp.entry.insn, exp.is_branch, exp.target,
                         act.entry.pc, act.entry.insn, act.is_branch, act.target);
                insn_errors++;
        end
endtask

task automatic note_failure(input string what);
        $display("%s", what);
        other_errors++;
endtask

function automatic int total_errors();
        return word_errors + insn_errors + other_errors;
endfunction

/* verification/tb_fetch_subsystem.sv */
// testbench for the fetch subsystem with a byte-array memory model and branch walker.
`timescale 1ns/10ps
`include "mem_macros.svh"

module tb_fetch_subsystem;

        localparam int MEM_BYTES = `MEM_SIZE_BYTES;
        localparam int NUM_RW = 48;
        localparam int NUM_STRAIGHT = 40;
        localparam int BRANCH_PROG = 32;
        localparam int NUM_BRANCH = 60;
        localparam int NUM_COLLIDE = 60;
        localparam int IDLE_LIMIT = 200;
        localparam int PLANNED_OPS = 2 * NUM_RW + 2 * NUM_STRAIGHT + 16 + BRANCH_PROG
                                   + 2 * NUM_BRANCH + 3 * NUM_COLLIDE + 16;
        localparam int CYCLE_LIMIT = 40 * PLANNED_OPS + 200;
        localparam logic [31:0] BRANCH_BASE = 32'h400;
        localparam logic [31:0] COLLIDE_BASE = 32'h600;
        localparam logic [31:0] DATA_BASE = 32'hC00;

        logic                  i_clk = 1'b0;
        logic                  i_rst_n;
        mem_pkg::rw_req_t      i_rw_req;
        logic                  i_fetch_en;
        logic [31:0]           i_start_pc;
        logic                  i_take;
        mem_pkg::word_t        o_rw_rdata;
        logic                  o_insn_valid;
        fetch_pkg::predecode_t o_insn;

        logic [7:0]     model_mem [MEM_BYTES] = '{default: 8'h00};     // mirrors every write.
        mem_pkg::addr_t data_addrs [$];
        int             cycle_count = 0;

        `include "tb_fetch_checks.svh"

        fetch_subsystem_top UUT (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_rw_req     (i_rw_req),
                .i_fetch_en   (i_fetch_en),
                .i_start_pc   (i_start_pc),
                .i_take       (i_take),
                .o_rw_rdata   (o_rw_rdata),
                .o_insn_valid (o_insn_valid),
                .o_insn       (o_insn)
        );

        always #10 i_clk = ~i_clk;

        always @(posedge i_clk)
                cycle_count <= cycle_count + 1;

        initial
        begin
                wait (cycle_count >= CYCLE_LIMIT);
                $display("timeout: no end of test after %0d cycles", cycle_count);
                $display("ERRORS FOUND");
                $finish;
        end

        task automatic next_cycle();
                @(posedge i_clk);
                #2;                                     // drive and sample point.
        endtask

        function automatic mem_pkg::word_t model_word(input mem_pkg::addr_t addr);
                int a;
                a = int'({addr[31:2], 2'b00});
                return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
        endfunction

        // expected predecode of the word at pc, by the branch rule.
        function automatic fetch_pkg::predecode_t expect_insn(input fetch_pkg::pc_t pc);
                fetch_pkg::predecode_t p;
                logic [31:0]           sext;
                p.entry.pc = pc;
                p.entry.insn = model_word(pc);
                p.is_branch = (p.entry.insn[31:24] == fetch_pkg::BRANCH_OPCODE);
                sext = {{8{p.entry.insn[23]}}, p.entry.insn[23:0]};
                p.target = pc + 32'd8 + (sext << 2);
                return p;
        endfunction

        function automatic mem_pkg::word_t plain_word();
                mem_pkg::word_t w;
                w = $urandom;
                if (w[31:24] == fetch_pkg::BRANCH_OPCODE)
                        w[31:24] = 8'h00;               // keep it a non-branch.
                return w;
        endfunction

        task automatic drive_write(input mem_pkg::addr_t addr, input mem_pkg::word_t data,
                                   input mem_pkg::ben_t ben);
                i_rw_req = '0;
                i_rw_req.wen = 1'b1;
                i_rw_req.ben = ben;
                i_rw_req.addr = addr;
                i_rw_req.wdata = data;
                for (int b = 0; b < 4; b++)
                begin
                        if (ben[b])
                                model_mem[int'({addr[31:2], 2'b00}) + b] = data[8*b +: 8];
                end
        endtask

        task automatic write_mem(input mem_pkg::addr_t addr, input mem_pkg::word_t data,
                                 input mem_pkg::ben_t ben);
                drive_write(addr, data, ben);
                next_cycle();
                i_rw_req = '0;
        endtask

        task automatic read_mem(input mem_pkg::addr_t addr, output mem_pkg::word_t data);
                i_rw_req = '0;
                i_rw_req.ren = 1'b1;
                i_rw_req.addr = addr;
                next_cycle();
                i_rw_req = '0;
                data = o_rw_rdata;                      // registered at the last edge.
        endtask

        task automatic load_branchy(input logic [31:0] base, input int n);
                int t;
                int off;
                for (int i = 0; i < n; i++)
                begin
                        if (i == n - 1 || ($urandom % 100) < 20)
                        begin
                                t = $urandom % n;
                                off = t - i - 2;        // word offset from pc plus 8.
                                write_mem(base + 4 * i, {fetch_pkg::BRANCH_OPCODE, off[23:0]}, 4'hF);
                        end
                        else
                                write_mem(base + 4 * i, plain_word(), 4'hF);
                end
        endtask

        // writes land past anything the fetch unit can already hold.
        task automatic inject_write(input fetch_pkg::pc_t last_pc, input bit fresh);
                mem_pkg::addr_t addr;
                mem_pkg::word_t data;
                if ($urandom % 2)
                begin
                        addr = DATA_BASE + 4 * ($urandom % 256);
                        data = $urandom;
                        data_addrs.push_back(addr);
                end
                else
                begin
                        // just after a pop at most three words sit past last_pc.
                        addr = last_pc + (fresh ? 32'd16 : 32'd20) + 4 * ($urandom % 3);
                        data = plain_word();
                end
                drive_write(addr, data, 4'($urandom));
        endtask

        task automatic run_stream(input string name, input logic [31:0] start_pc, input int n,
                                  input int take_pct, input bit inject);
                fetch_pkg::predecode_t exp;
                fetch_pkg::pc_t        exp_pc;
                fetch_pkg::pc_t        last_pc;
                bit                    fresh;
                int                    got;
                int                    idle;
                exp_pc = start_pc;
                last_pc = start_pc - 32'd4;
                fresh = 1'b0;
                got = 0;
                idle = 0;
                i_start_pc = start_pc;
                i_fetch_en = 1'b1;
                while (got < n && idle < IDLE_LIMIT)
                begin
                        i_take = (($urandom % 100) < take_pct);
                        if (inject)
                                inject_write(last_pc, fresh);
                        next_cycle();
                        i_rw_req = '0;
                        if (o_insn_valid === 1'b1)
                        begin
                                exp = expect_insn(exp_pc);
                                check_insn(name, exp, o_insn);
                                last_pc = exp.entry.pc;
                                exp_pc = exp.is_branch ? exp.target : exp_pc + 32'd4;
                                fresh = 1'b1;
                                got++;
                                idle = 0;
                        end
                        else
                        begin
                                fresh = 1'b0;
                                idle++;
                        end
                end
                if (idle >= IDLE_LIMIT)
                        note_failure($sformatf("%s: o_insn_valid missing for %0d cycles",
                                               name, IDLE_LIMIT));
        endtask

        // stop fetch and empty the queue before the next program.
        task automatic drain();
                i_fetch_en = 1'b0;
                i_take = 1'b0;
                repeat (3) next_cycle();
                i_take = 1'b1;
                repeat (8) next_cycle();
                i_take = 1'b0;
                repeat (2) next_cycle();
        endtask

        initial
        begin
                int unsigned    seed;
                logic [31:0]    base;
                logic [31:0]    start;
                mem_pkg::addr_t addr;
                mem_pkg::word_t got;
                i_rst_n = 1'b0;
                i_rw_req = '0;
                i_fetch_en = 1'b0;
                i_start_pc = '0;
                i_take = 1'b0;
                seed = $urandom(27);
                repeat (16) @(posedge i_clk);
                #2;
                i_rst_n = 1'b1;
                next_cycle();

                for (int i = 0; i < NUM_RW; i++)
                begin
                        addr = 32'($urandom % MEM_BYTES);
                        write_mem(addr, $urandom, 4'($urandom));
                        read_mem(addr, got);
                        check_word("byte_write", model_word(addr), got);
                end

                start = 4 * ($urandom % 64);
                for (int i = 0; i < NUM_STRAIGHT + 16; i++)
                        write_mem(start + 4 * i, plain_word(), 4'hF);
                run_stream("straight_line", start, NUM_STRAIGHT, 100, 1'b0);
                drain();

                base = BRANCH_BASE + 4 * ($urandom % 32);
                load_branchy(base, BRANCH_PROG);
                start = base + 4 * ($urandom % BRANCH_PROG);
                run_stream("branch", start, NUM_BRANCH, 100, 1'b0);
                drain();
                run_stream("back_pressure", start, NUM_BRANCH, 30, 1'b0);   // same stream.
                drain();

                base = COLLIDE_BASE + 4 * ($urandom % 64);
                for (int i = 0; i < NUM_COLLIDE + 16; i++)
                        write_mem(base + 4 * i, plain_word(), 4'hF);
                run_stream("collision", base, NUM_COLLIDE, 60, 1'b1);
                drain();
                foreach (data_addrs[i])
                begin
                        read_mem(data_addrs[i], got);
                        check_word("collision_data", model_word(data_addrs[i]), got);
                end

                $display("word errors: %0d, instruction errors: %0d, other errors: %0d",
                         word_errors, insn_errors, other_errors);
                if (total_errors() == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule
